//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tbDag
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/clockGen.sv
/*
 * Testbench clock source, free running.
 */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter real Period = 8.0  // Clock period in ns.
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(Period / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- bench/dagTestdata.mem
// req1 acc1 req2 acc2 | expected next cycle: flags(dmV,pmV,w1,w2,conf) dmAddr pmAddr dmdOut
// req: gen,postMod,iSel,mSel,toPm   acc: wr,rd,kind,idx,data[13:0]
40 00000 00 00000 10 0000 0000 0000
00 94005 00 00000 00 0000 0000 0000
00 A4003 00 00000 00 0000 0000 0000
00 84102 00 00000 00 0000 0000 0000
00 54000 00 00000 00 0000 0000 0005
00 64000 00 00000 00 0000 0000 0003
00 44000 00 00000 00 0000 0000 0102
00 00000 00 00000 00 0000 0000 0000
6A 00000 00 00000 14 0102 0000 0000
6A 00000 00 00000 10 0100 0000 0000
6A 00000 00 00000 14 0103 0000 0000
6A 00000 00 00000 10 0101 0000 0000
00 ABFFE 00 00000 00 0000 0000 0000
6C 00000 00 00000 10 0104 0000 0000
6C 00000 00 00000 10 0102 0000 0000
6C 00000 00 00000 14 0100 0000 0000
6C 00000 00 00000 10 0103 0000 0000
00 A1000 00 00000 00 0000 0000 0000
60 00000 00 00000 10 0000 0000 0000
60 00000 00 00000 10 1000 0000 0000
60 00000 00 00000 10 2000 0000 0000
60 00000 00 00000 10 3000 0000 0000
60 00000 00 00000 10 0000 0000 0000
00 AFFFB 00 00000 00 0000 0000 0000
66 00000 00 00000 10 1000 0000 0000
66 00000 00 00000 10 0FFB 0000 0000
00 00000 00 00000 00 0000 0000 0000
00 00000 00 80200 00 0000 0000 0000
00 00000 00 84300 00 0000 0000 0000
00 00000 00 A0001 00 0000 0000 0000
00 00000 61 00000 08 0000 0200 0000
00 00000 60 00000 10 0201 0000 0000
40 00000 40 00000 11 0FF6 0000 0000
40 00000 49 00000 18 0FF6 0300 0000
41 00000 00 00000 10 0FF6 0000 0000
00 00000 00 40000 00 0000 0000 0202
00 00000 00 94004 00 0000 0000 0000
00 00000 00 84303 00 0000 0000 0000
00 00000 68 00000 12 0303 0000 0000
00 00000 68 00000 10 0300 0000 0000
00 00000 00 00000 00 0000 0000 0000

//--- bench/tbDag.sv
/*
 * Data address generator testbench.
 * Replays file vectors on both units and checks the buses one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module tbDag;
  import dagPkg::*;

  localparam int NumVecs    = 41;  // Lines in the vector file.
  localparam int WordsPerVec = 8;
  localparam int ResetCycles = 5;
  localparam int IdleVecs    = 2;
  localparam int CycleLimit  = NumVecs + IdleVecs + ResetCycles + 20;

  typedef struct packed {
    logic    dmValid;
    logic    pmValid;
    logic    dag1Wrap;
    logic    dag2Wrap;
    logic    busConflict;
    dagAddrT dmAddr;
    dagAddrT pmAddr;
    dagDataT dmdOut;
  } expectT;

  logic       DSPCLK;
  logic       rst;
  dagReqT     dag1Req;
  regAccessT  dag1Access;
  dagReqT     dag2Req;
  regAccessT  dag2Access;
  dagAddrT    dmAddr;
  logic       dmValid;
  dagAddrT    pmAddr;
  logic       pmValid;
  dagDataT    dmdOut;
  logic       dag1Wrap;
  logic       dag2Wrap;
  logic       busConflict;

  logic [19:0] vecMem [NumVecs*WordsPerVec];
  expectT      pending;  // Expected outputs for the cycle being checked.
  int          seed;
  int          cycleCount;

  clockGen #(.Period(8.0)) clkSrc (.clk(DSPCLK));

  dagTop UUT (
    .DSPCLK     (DSPCLK),
    .rst        (rst),
    .dag1Req    (dag1Req),
    .dag1Access (dag1Access),
    .dag2Req    (dag2Req),
    .dag2Access (dag2Access),
    .dmAddr     (dmAddr),
    .dmValid    (dmValid),
    .pmAddr     (pmAddr),
    .pmValid    (pmValid),
    .dmdOut     (dmdOut),
    .dag1Wrap   (dag1Wrap),
    .dag2Wrap   (dag2Wrap),
    .busConflict(busConflict)
  );

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("ERR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
    $display("CHECKS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic checkAddr(input string name, input dagAddrT expVal, input dagAddrT actVal);
    if (actVal !== expVal) reportMismatch(name, 32'(expVal), 32'(actVal));
  endtask

  task automatic checkData(input string name, input dagDataT expVal, input dagDataT actVal);
    if (actVal !== expVal) reportMismatch(name, 32'(expVal), 32'(actVal));
  endtask

  task automatic checkFlag(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) reportMismatch(name, 32'(expVal), 32'(actVal));
  endtask

  // Addresses are only compared while their bus is valid.
  task automatic checkOutputs(input expectT exp);
    checkFlag("dmValid", exp.dmValid, dmValid);
    checkFlag("pmValid", exp.pmValid, pmValid);
    if (exp.dmValid) checkAddr("dmAddr", exp.dmAddr, dmAddr);
    if (exp.pmValid) checkAddr("pmAddr", exp.pmAddr, pmAddr);
    checkData("dmdOut", exp.dmdOut, dmdOut);
    checkFlag("dag1Wrap", exp.dag1Wrap, dag1Wrap);
    checkFlag("dag2Wrap", exp.dag2Wrap, dag2Wrap);
    checkFlag("busConflict", exp.busConflict, busConflict);
  endtask

  // Drive one cycle and check the result of the previous one.
  task automatic stepVec(input dagReqT r1, input regAccessT a1, input dagReqT r2,
                         input regAccessT a2, input expectT exp);
    @(posedge DSPCLK);
    dag1Req    <= r1;
    dag1Access <= a1;
    dag2Req    <= r2;
    dag2Access <= a2;
    @(negedge DSPCLK);
    checkOutputs(pending);
    pending = exp;
  endtask

  function automatic expectT unpackExpect(input int base);
    expectT e;
    e.dmValid     = vecMem[base+4][4];
    e.pmValid     = vecMem[base+4][3];
    e.dag1Wrap    = vecMem[base+4][2];
    e.dag2Wrap    = vecMem[base+4][1];
    e.busConflict = vecMem[base+4][0];
    e.dmAddr      = vecMem[base+5][AddrWidth-1:0];
    e.pmAddr      = vecMem[base+6][AddrWidth-1:0];
    e.dmdOut      = vecMem[base+7][DataWidth-1:0];
    return e;
  endfunction

  always @(posedge DSPCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int       base;
    int       rnd;
    dagReqT    idleReq;
    regAccessT idleAcc;
    seed       = 71364;
    cycleCount = 0;
    rst        = 1'b1;
    dag1Req    = '0;
    dag1Access = '0;
    dag2Req    = '0;
    dag2Access = '0;
    pending    = '0;  // Reset state is all zero.
    $readmemh("bench/dagTestdata.mem", vecMem);
    repeat (ResetCycles) @(posedge DSPCLK);
    rst <= 1'b0;

    // Idle cycles with random don't-care fields.
    for (int i = 0; i < IdleVecs; i++) begin
      rnd     = $random(seed);
      idleReq = dagReqT'({1'b0, rnd[5:0]});
      idleAcc = regAccessT'({2'b00, rnd[23:6]});
      stepVec(idleReq, idleAcc, '0, '0, '0);
    end

    for (int k = 0; k < NumVecs; k++) begin
      base = k * WordsPerVec;
      stepVec(dagReqT'(vecMem[base][6:0]), regAccessT'(vecMem[base+1]),
              dagReqT'(vecMem[base+2][6:0]), regAccessT'(vecMem[base+3]),
              unpackExpect(base));
    end
    stepVec('0, '0, '0, '0, '0);  // Flush the last result.

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/dagBusMux.sv
/*
 * Merges both unit results onto the DM and PM address buses.
 * ORs the readback words and flags DM bus conflicts.
 */
`timescale 1ns/1ps
`default_nettype none

module dagBusMux (
  input  logic              DSPCLK,
  input  dagPkg::dagResultT dag1Result,
  input  dagPkg::dagResultT dag2Result,
  input  dagPkg::dagDataT   dag1Data,
  input  dagPkg::dagDataT   dag2Data,
  output dagPkg::dagAddrT   dmAddr,
  output logic              dmValid,
  output dagPkg::dagAddrT   pmAddr,
  output logic              pmValid,
  output dagPkg::dagDataT   dmdOut,
  output logic              dag1Wrap,
  output logic              dag2Wrap,
  output logic              busConflict
);

  logic dag2ToDm;
  logic dag2ToPm;

  assign dag2ToDm = dag2Result.valid & ~dag2Result.toPm;
  assign dag2ToPm = dag2Result.valid & dag2Result.toPm;

  // DM bus, unit 1 has priority.
  always_comb begin
    if (dag1Result.valid) begin
      dmAddr = dag1Result.addr;  // Unit 1 toPm ignored.
    end else if (dag2ToDm) begin
      dmAddr = dag2Result.addr;
    end else begin
      dmAddr = '0;
    end
  end

  assign dmValid = dag1Result.valid | dag2ToDm;

  // PM bus belongs to unit 2 only.
  assign pmValid = dag2ToPm;
  assign pmAddr  = dag2ToPm ? dag2Result.addr : '0;

  // Unit 2 loses its DM cycle.
  assign busConflict = dag1Result.valid & dag2ToDm;

  assign dag1Wrap = dag1Result.valid & dag1Result.wrap;
  assign dag2Wrap = dag2Result.valid & dag2Result.wrap;

  assign dmdOut = dag1Data | dag2Data;

  // Only one unit may drive readback at a time.
  aOneReader: assert property (@(posedge DSPCLK)
    !((|dag1Data) && (|dag2Data)))
    else $error("dagBusMux: both units drive readback");

endmodule

`default_nettype wire

//--- rtl/dagPkg.sv
/*
 * Data address generator shared definitions.
 * Widths, register counts and the request, access and result structs.
 */
`default_nettype none

package dagPkg;

  localparam int AddrWidth   = 14;  // Address and I/L/M register width.
  localparam int DataWidth   = 16;  // Register readback bus width.
  localparam int NumRegs     = 4;   // Registers of each kind per unit.
  localparam int RegSelWidth = $clog2(NumRegs);

  // Signed sum width for the circular buffer fold, room for sign and carry.
  localparam int ModSumWidth = AddrWidth + 2;

  typedef logic [AddrWidth-1:0] dagAddrT;
  typedef logic [DataWidth-1:0] dagDataT;

  // Register kind for access strobes.
  typedef enum logic [1:0] {
    kindI = 2'd0,  // Index.
    kindL = 2'd1,  // Buffer length.
    kindM = 2'd2   // Modify step.
  } regKindE;

  // Address request, one strobe per cycle.
  typedef struct packed {
    logic                   gen;      // Issue an address.
    logic                   postMod;  // Write I back after issue.
    logic [RegSelWidth-1:0] iSel;     // I/L pair.
    logic [RegSelWidth-1:0] mSel;     // M register.
    logic                   toPm;     // Target is program memory.
  } dagReqT;

  // Register write or read.
  typedef struct packed {
    logic                   wr;    // Write strobe.
    logic                   rd;    // Read strobe.
    regKindE                kind;
    logic [RegSelWidth-1:0] idx;
    dagAddrT                data;  // Write data.
  } regAccessT;

  // One unit's registered output.
  typedef struct packed {
    logic    valid;
    logic    toPm;
    logic    wrap;   // Post-modify folded at the buffer end.
    dagAddrT addr;
  } dagResultT;

endpackage

`default_nettype wire

//--- rtl/dagTop.sv
/*
 * Data address generator top level.
 * Two address units feeding the shared DM, PM and readback buses.
 */
`timescale 1ns/1ps
`default_nettype none

module dagTop (
  input  logic              DSPCLK,
  input  logic              rst,
  input  dagPkg::dagReqT    dag1Req,
  input  dagPkg::regAccessT dag1Access,
  input  dagPkg::dagReqT    dag2Req,
  input  dagPkg::regAccessT dag2Access,
  output dagPkg::dagAddrT   dmAddr,
  output logic              dmValid,
  output dagPkg::dagAddrT   pmAddr,
  output logic              pmValid,
  output dagPkg::dagDataT   dmdOut,
  output logic              dag1Wrap,
  output logic              dag2Wrap,
  output logic              busConflict
);
  import dagPkg::*;

  dagResultT dag1Result;
  dagResultT dag2Result;
  dagDataT   dag1Data;
  dagDataT   dag2Data;

  ilmRegFile dag1 (
    .DSPCLK  (DSPCLK),
    .rst     (rst),
    .req     (dag1Req),
    .access  (dag1Access),
    .result  (dag1Result),
    .readData(dag1Data)
  );

  ilmRegFile dag2 (
    .DSPCLK  (DSPCLK),
    .rst     (rst),
    .req     (dag2Req),
    .access  (dag2Access),
    .result  (dag2Result),
    .readData(dag2Data)
  );

  dagBusMux busMux (
    .DSPCLK     (DSPCLK),
    .dag1Result (dag1Result),
    .dag2Result (dag2Result),
    .dag1Data   (dag1Data),
    .dag2Data   (dag2Data),
    .dmAddr     (dmAddr),
    .dmValid    (dmValid),
    .pmAddr     (pmAddr),
    .pmValid    (pmValid),
    .dmdOut     (dmdOut),
    .dag1Wrap   (dag1Wrap),
    .dag2Wrap   (dag2Wrap),
    .busConflict(busConflict)
  );

endmodule

`default_nettype wire

//--- rtl/ilmRegFile.sv
/*
 * One address unit with four I, L and M registers.
 * Issues I as an address, post-modifies it and serves register readback.
 */
`timescale 1ns/1ps
`default_nettype none

module ilmRegFile (
  input  logic              DSPCLK,
  input  logic              rst,
  input  dagPkg::dagReqT    req,
  input  dagPkg::regAccessT access,
  output dagPkg::dagResultT result,
  output dagPkg::dagDataT   readData
);
  import dagPkg::*;

  dagAddrT iReg [NumRegs];
  dagAddrT lReg [NumRegs];
  dagAddrT mReg [NumRegs];

  dagAddrT curI;
  dagAddrT curL;
  dagAddrT curM;
  dagAddrT nextI;
  dagAddrT rdVal;
  logic    modWrap;
  logic    doPostMod;

  logic    resValid;
  logic    resToPm;
  logic    resWrap;
  dagAddrT resAddr;

  // Selected operands for this cycle's request.
  assign curI = iReg[req.iSel];
  assign curL = lReg[req.iSel];  // L is paired with I.
  assign curM = mReg[req.mSel];

  moduloUpdate modUpd (
    .index    (curI),
    .length   (curL),
    .modify   (curM),
    .nextIndex(nextI),
    .wrap     (modWrap)
  );

  assign doPostMod = req.gen & req.postMod;

  // Register bank.
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      for (int r = 0; r < NumRegs; r++) begin
        iReg[r] <= '0;
        lReg[r] <= '0;
        mReg[r] <= '0;
      end
    end else begin
      if (doPostMod) begin
        iReg[req.iSel] <= nextI;  // Visible to the next gen.
      end
      if (access.wr) begin
        case (access.kind)
          kindI:   iReg[access.idx] <= access.data;
          kindL:   lReg[access.idx] <= access.data;
          kindM:   mReg[access.idx] <= access.data;
          default: ;
        endcase
      end
    end
  end

  // Readback source.
  always_comb begin
    case (access.kind)
      kindI:   rdVal = iReg[access.idx];
      kindL:   rdVal = lReg[access.idx];
      kindM:   rdVal = mReg[access.idx];
      default: rdVal = '0;
    endcase
  end

  // Result flags and readback, one cycle after the strobe.
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      resValid <= 1'b0;
      resToPm  <= 1'b0;
      resWrap  <= 1'b0;
      readData <= '0;
    end else begin
      resValid <= req.gen;
      resToPm  <= req.gen & req.toPm;
      resWrap  <= doPostMod & modWrap;  // Only a real update reports a fold.
      if (access.rd) begin
        readData <= {{(DataWidth - AddrWidth){1'b0}}, rdVal};
      end else begin
        readData <= '0;  // Idle unit keeps the shared bus clear.
      end
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (req.gen) begin
      resAddr <= curI;  // Pre-modify index.
    end
  end

  assign result = '{valid: resValid, toPm: resToPm, wrap: resWrap, addr: resAddr};

  aNoWrRd: assert property (@(posedge DSPCLK) disable iff (rst)
    !(access.wr && access.rd))
    else $error("ilmRegFile: write and read strobed together");

  // Post-modify and a write to the same I would race.
  aNoIClash: assert property (@(posedge DSPCLK) disable iff (rst)
    !(doPostMod && access.wr && access.kind == kindI && access.idx == req.iSel))
    else $error("ilmRegFile: write hits I%0d during post-modify", req.iSel);

endmodule

`default_nettype wire

//--- rtl/moduloUpdate.sv
/*
 * Circular buffer next-index arithmetic.
 * Adds a signed modify to the index and folds it back into the buffer.
 */
`timescale 1ns/1ps
`default_nettype none

module moduloUpdate (
  input  dagPkg::dagAddrT index,
  input  dagPkg::dagAddrT length,
  input  dagPkg::dagAddrT modify,
  output dagPkg::dagAddrT nextIndex,
  output logic            wrap
);
  import dagPkg::*;

  logic [AddrWidth-1:0] lenMinus1;
  logic [AddrWidth-1:0] mask;
  dagAddrT              base;
  dagAddrT              modMag;
  logic signed [ModSumWidth-1:0] sumWide;
  logic signed [ModSumWidth-1:0] lenWide;
  logic signed [ModSumWidth-1:0] bufLow;
  logic signed [ModSumWidth-1:0] bufHigh;
  logic signed [ModSumWidth-1:0] nextWide;
  logic startInside;
  logic stepFits;

  // Smear L-1 downward to get the 2^k - 1 mask.
  always_comb begin
    lenMinus1 = length - dagAddrT'(1);
    mask[AddrWidth-1] = lenMinus1[AddrWidth-1];
    for (int i = AddrWidth - 2; i >= 0; i--) begin
      mask[i] = mask[i+1] | lenMinus1[i];
    end
  end

  assign base = index & ~mask;  // Buffer start, aligned to 2^k.

  assign sumWide = $signed({2'b00, index}) + $signed({{2{modify[AddrWidth-1]}}, modify});
  assign lenWide = $signed({2'b00, length});
  assign bufLow  = $signed({2'b00, base});
  assign bufHigh = bufLow + lenWide;  // One past the last entry.

  // Fold the sum back into the buffer.
  always_comb begin
    if (length == '0) begin
      nextWide = sumWide;  // Linear mode.
      wrap     = 1'b0;
    end else if (sumWide >= bufHigh) begin
      nextWide = sumWide - lenWide;  // Ran off the top.
      wrap     = 1'b1;
    end else if (sumWide < bufLow) begin
      nextWide = sumWide + lenWide;  // Ran off the bottom.
      wrap     = 1'b1;
    end else begin
      nextWide = sumWide;
      wrap     = 1'b0;
    end
  end

  // Truncation gives the modulo 2^14 result in linear mode.
  assign nextIndex = nextWide[AddrWidth-1:0];

  assign modMag      = modify[AddrWidth-1] ? dagAddrT'(-modify) : modify;
  assign startInside = $signed({2'b00, index}) < bufHigh;
  assign stepFits    = modMag <= length;

  // A legal step from inside the buffer must land inside it.
  always_comb begin
    if (length != '0 && startInside && stepFits) begin
      assert ((nextIndex & ~mask) == base && (nextIndex & mask) < length)
        else $error("moduloUpdate: next index %0h outside buffer", nextIndex);
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/dagPkg.sv
rtl/moduloUpdate.sv
rtl/ilmRegFile.sv
rtl/dagBusMux.sv
rtl/dagTop.sv
bench/clockGen.sv
bench/tbDag.sv
